//--- Bender.yml
package:
  name: rv32im_fetch

sources:
  - include_dirs:
      - .
    files:
      - rv32im_pkg.sv
      - rv32im_prefetch.sv
      - rv32im_pc_unit.sv
      - rv32im_bus_arbiter.sv
      - rv32im_wb_memory.sv
      - rv32im_fetch_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - rv32im_fetch_top_tb.sv

//--- rv32im_bus_arbiter.sv
`timescale 1ns/100ps

module rv32im_bus_arbiter (
    input  logic              clk_i,
    input  logic              reset_i,

    // m0, prefetch unit, read only.
    input  logic              m0_req_i,
    input  logic              m0_stb_i,
    input  rv32im_pkg::wadr_t m0_adr_i,
    output logic              m0_grant_o,

    // m1, data port, wins ties.
    input  logic              m1_req_i,
    input  logic              m1_stb_i,
    input  logic              m1_we_i,
    input  rv32im_pkg::wadr_t m1_adr_i,
    input  rv32im_pkg::word_t m1_dat_i,
    output logic              m1_grant_o,

    // shared return path, qualified by each master's grant.
    output logic              m_ack_o,
    output logic              m_err_o,
    output rv32im_pkg::word_t m_dat_o,

    // slave side.
    input  logic              s_ack_i,
    input  logic              s_err_i,
    input  rv32im_pkg::word_t s_dat_i,
    output logic              s_cyc_o,
    output logic              s_stb_o,
    output logic              s_we_o,
    output rv32im_pkg::wadr_t s_adr_o,
    output rv32im_pkg::word_t s_dat_o
);

    rv32im_pkg::bus_sm_e state_q;
    logic                owner_q; // 1 means m1.
    logic                owner_req;

    assign owner_req = owner_q ? m1_req_i : m0_req_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= rv32im_pkg::IDLE;
            owner_q <= 1'b0;
        end else if (state_q == rv32im_pkg::IDLE) begin
            if (m1_req_i || m0_req_i) begin
                owner_q <= m1_req_i;
                state_q <= rv32im_pkg::WAIT;
            end
        end else if (!owner_req) begin
            state_q <= rv32im_pkg::IDLE; // one idle cycle between owners.
        end
    end

    assign m0_grant_o = (state_q == rv32im_pkg::WAIT) & ~owner_q;
    assign m1_grant_o = (state_q == rv32im_pkg::WAIT) & owner_q;

    assign s_stb_o = (m0_grant_o & m0_stb_i) | (m1_grant_o & m1_stb_i);
    assign s_cyc_o = s_stb_o;
    assign s_we_o  = m1_grant_o & m1_we_i;
    assign s_adr_o = owner_q ? m1_adr_i : m0_adr_i;
    assign s_dat_o = m1_dat_i;

    assign m_ack_o = s_ack_i;
    assign m_err_o = s_err_i;
    assign m_dat_o = s_dat_i;

    // an answer must still find its master granted.
    answer_while_granted: assert property (@(posedge clk_i) disable iff (reset_i)
        (s_ack_i || s_err_i) |-> (m0_grant_o || m1_grant_o));

endmodule

//--- rv32im_defines.svh
`ifndef RV32IM_DEFINES_SVH
`define RV32IM_DEFINES_SVH

////////////////////////////////////////////////////////////
// core widths
////////////////////////////////////////////////////////////

// data and byte address width.
`define RV32IM_XLEN 32

// bus word address, byte offset dropped.
`define RV32IM_WADR_W 30

////////////////////////////////////////////////////////////
// memory and reset
////////////////////////////////////////////////////////////

`define RV32IM_MEM_WORDS 256

`define RV32IM_RESET_PC 32'h0000_0000

`endif

//--- rv32im_fetch_top.f
+incdir+.
rv32im_pkg.sv
rv32im_prefetch.sv
rv32im_pc_unit.sv
rv32im_bus_arbiter.sv
rv32im_wb_memory.sv
rv32im_fetch_top.sv
rv32im_fetch_top_tb.sv

//--- rv32im_fetch_top.sv
`timescale 1ns/100ps

module rv32im_fetch_top (
    input  logic              clk_i,
    input  logic              reset_i,

    input  logic              advance_i,
    input  logic              irq_i,
    input  rv32im_pkg::word_t vtable_base_i,
    input  rv32im_pkg::word_t irq_cause_i, // byte offset into the table.

    output rv32im_pkg::word_t instr_o,
    output logic              instr_valid_o,
    output logic              fetch_fault_o,
    output rv32im_pkg::word_t pc_o,
    output rv32im_pkg::word_t uepc_o,
    output logic              initialized_o,

    // data port, ack/err/dat belong to it while dport_grant_o is high.
    input  logic              dport_req_i,
    input  logic              dport_we_i,
    input  rv32im_pkg::wadr_t dport_adr_i,
    input  rv32im_pkg::word_t dport_dat_i,
    output logic              dport_grant_o,
    output logic              dport_ack_o,
    output logic              dport_err_o,
    output rv32im_pkg::word_t dport_dat_o
);

    // prefetch to pc unit.
    logic              data_ready;
    rv32im_pkg::word_t interrupt_pc;
    logic              interrupt_pc_write;
    logic              save_uepc;

    // prefetch master port.
    logic              pf_req;
    logic              pf_stb;
    logic              pf_grant;
    rv32im_pkg::wadr_t pf_adr;

    // arbiter to memory.
    logic              s_cyc;
    logic              s_stb;
    logic              s_we;
    rv32im_pkg::wadr_t s_adr;
    rv32im_pkg::word_t s_wdat;
    rv32im_pkg::word_t s_rdat;
    logic              s_ack;
    logic              s_err;

    assign instr_valid_o = data_ready;

    rv32im_prefetch u_prefetch (
        .clk_i(clk_i), .reset_i(reset_i), .program_counter_i(pc_o),
        .advance_i(advance_i), .data_ready_o(data_ready), .instruction_o(instr_o),
        .fetch_fault_o(fetch_fault_o), .ctrl_req_o(pf_req), .ctrl_grant_i(pf_grant),
        .master_dat_i(dport_dat_o), .ack_i(dport_ack_o), .err_i(dport_err_o),
        .adr_o(pf_adr), .stb_o(pf_stb), .interrupt_trigger_i(irq_i),
        .vtable_addr_i(vtable_base_i), .vtable_offset_i(irq_cause_i),
        .interrupt_pc_o(interrupt_pc), .interrupt_pc_write_o(interrupt_pc_write),
        .initialized_o(initialized_o), .save_uepc_o(save_uepc)
    );

    rv32im_pc_unit u_pc_unit (
        .clk_i(clk_i), .reset_i(reset_i), .data_ready_i(data_ready),
        .interrupt_pc_i(interrupt_pc), .interrupt_pc_write_i(interrupt_pc_write),
        .save_uepc_i(save_uepc), .pc_o(pc_o), .uepc_o(uepc_o)
    );

    // data port stb follows its req.
    rv32im_bus_arbiter u_arbiter (
        .clk_i(clk_i), .reset_i(reset_i),
        .m0_req_i(pf_req), .m0_stb_i(pf_stb), .m0_adr_i(pf_adr), .m0_grant_o(pf_grant),
        .m1_req_i(dport_req_i), .m1_stb_i(dport_req_i), .m1_we_i(dport_we_i),
        .m1_adr_i(dport_adr_i), .m1_dat_i(dport_dat_i), .m1_grant_o(dport_grant_o),
        .m_ack_o(dport_ack_o), .m_err_o(dport_err_o), .m_dat_o(dport_dat_o),
        .s_ack_i(s_ack), .s_err_i(s_err), .s_dat_i(s_rdat),
        .s_cyc_o(s_cyc), .s_stb_o(s_stb), .s_we_o(s_we), .s_adr_o(s_adr), .s_dat_o(s_wdat)
    );

    rv32im_wb_memory u_memory (
        .clk_i(clk_i), .reset_i(reset_i), .cyc_i(s_cyc), .stb_i(s_stb), .we_i(s_we),
        .adr_i(s_adr), .dat_i(s_wdat), .dat_o(s_rdat), .ack_o(s_ack), .err_o(s_err)
    );

endmodule

//--- rv32im_fetch_top_tb.sv
`timescale 1ns/100ps
`include "rv32im_defines.svh"

module rv32im_fetch_top_tb;

    localparam int          timeout_cycles = 2000;
    localparam logic [31:0] table_base     = 32'h0000_0000;
    localparam logic [31:0] prog_base      = 32'h0000_0100;
    localparam logic [31:0] handler_pc     = 32'h0000_0200;
    localparam logic [31:0] bad_pc         = 32'h0000_1000; // beyond the 1 KiB memory.

    logic              clk;
    logic              reset;
    logic              advance;
    logic              irq;
    rv32im_pkg::word_t vtable_base;
    rv32im_pkg::word_t irq_cause;
    logic              dport_req;
    logic              dport_we;
    rv32im_pkg::wadr_t dport_adr;
    rv32im_pkg::word_t dport_wdat;
    rv32im_pkg::word_t instr;
    logic              instr_valid;
    logic              fault;
    rv32im_pkg::word_t pc;
    rv32im_pkg::word_t uepc;
    logic              initialized;
    logic              dport_grant;
    logic              dport_ack;
    logic              dport_err;
    rv32im_pkg::word_t dport_rdat;

    rv32im_pkg::word_t mirror [`RV32IM_MEM_WORDS]; // expected memory contents.
    int                errors = 0;
    int                checks = 0;
    int                grant_overlaps = 0;
    int                cycle_count = 0;
    int unsigned       seed;
    int unsigned       first_draw;

    rv32im_fetch_top dut (
        .clk_i(clk), .reset_i(reset), .advance_i(advance), .irq_i(irq),
        .vtable_base_i(vtable_base), .irq_cause_i(irq_cause),
        .instr_o(instr), .instr_valid_o(instr_valid), .fetch_fault_o(fault),
        .pc_o(pc), .uepc_o(uepc), .initialized_o(initialized),
        .dport_req_i(dport_req), .dport_we_i(dport_we), .dport_adr_i(dport_adr),
        .dport_dat_i(dport_wdat), .dport_grant_o(dport_grant), .dport_ack_o(dport_ack),
        .dport_err_o(dport_err), .dport_dat_o(dport_rdat)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == timeout_cycles) begin
            $display("timeout, run stopped after %0d cycles", timeout_cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (!reset && dport_grant && dut.pf_grant) begin
            grant_overlaps++;
            errors++;
            $display("ERR %0t: both bus grants high", $time);
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    // one data port request, answer qualified by the grant.
    task automatic dport_access(input logic we, input logic [31:0] byte_adr,
                                input rv32im_pkg::word_t wdata,
                                output rv32im_pkg::word_t rdata, output logic got_err);
        int waited;
        waited = 0;
        dport_req = 1'b1;
        dport_we = we;
        dport_adr = byte_adr[31:2];
        dport_wdat = wdata;
        do begin
            @(posedge clk);
            #2;
            waited++;
        end while (!(dport_grant && (dport_ack || dport_err)) && waited < 40);
        if (!(dport_grant && (dport_ack || dport_err))) begin
            errors++;
            $display("data port request to %h was never answered", byte_adr);
        end
        got_err = dport_err;
        rdata = dport_rdat;
        dport_req = 1'b0;
        dport_we = 1'b0;
        @(posedge clk); // req seen low, bus back to idle.
        #2;
    endtask

    task automatic dport_write(input logic [31:0] byte_adr, input rv32im_pkg::word_t data);
        rv32im_pkg::word_t unused;
        logic err;
        dport_access(1'b1, byte_adr, data, unused, err);
        check("data port write error", err, 1'b0);
        mirror[byte_adr[31:2]] = data;
    endtask

    task automatic dport_read(input logic [31:0] byte_adr, output rv32im_pkg::word_t data);
        logic err;
        dport_access(1'b0, byte_adr, '0, data, err);
        check("data port read error", err, 1'b0);
    endtask

    task automatic pulse_irq(input rv32im_pkg::word_t cause);
        irq_cause = cause;
        irq = 1'b1;
        @(posedge clk);
        #2;
        irq = 1'b0;
    endtask

    // ends one edge after the result, when pc has stepped.
    task automatic advance_and_wait(output logic got_valid, output logic got_fault,
                                    output rv32im_pkg::word_t word);
        int waited;
        waited = 0;
        advance = 1'b1;
        do begin
            @(posedge clk);
            #2;
            advance = 1'b0;
            waited++;
        end while (!instr_valid && !fault && waited < 40);
        got_valid = instr_valid;
        got_fault = fault;
        word = instr;
        if (!got_valid && !got_fault) begin
            errors++;
            $display("fetch after advance never completed");
        end
        @(posedge clk);
        #2;
    endtask

    // lookup has no visible done, so pc reaching the entry ends it.
    task automatic advance_for_vector(input rv32im_pkg::word_t expected_pc);
        int waited;
        int valid_seen;
        waited = 0;
        valid_seen = 0;
        advance = 1'b1;
        do begin
            @(posedge clk);
            #2;
            advance = 1'b0;
            waited++;
            if (instr_valid) valid_seen++;
        end while (pc !== expected_pc && waited < 40);
        check("pc after vector lookup", pc, expected_pc);
        check("instr_valid pulses in lookup", valid_seen, 0);
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    task automatic test_after_reset();
        int errors_before;
        errors_before = errors;
        check("instr_valid after reset", instr_valid, 1'b0);
        check("initialized after reset", initialized, 1'b0);
        check("dport_ack after reset", dport_ack, 1'b0);
        dport_write(table_base, prog_base); // entry 0.
        dport_write(table_base + 8, handler_pc);
        advance_for_vector(prog_base);
        finish_test("after_reset", errors_before);
    endtask

    task automatic test_sequential_fetch();
        int errors_before;
        int i;
        logic v;
        logic f;
        rv32im_pkg::word_t got;
        errors_before = errors;
        for (i = 0; i < 6; i++) dport_write(prog_base + 4 * i, $urandom());
        for (i = 0; i < 6; i++) begin
            advance_and_wait(v, f, got);
            check("instr_valid", v, 1'b1);
            check("fetched word", got, mirror[(prog_base >> 2) + i]);
            check("pc after fetch", pc, prog_base + 4 * (i + 1));
        end
        check("initialized", initialized, 1'b1);
        finish_test("sequential_fetch", errors_before);
    endtask

    task automatic test_interrupt();
        int errors_before;
        logic v;
        logic f;
        rv32im_pkg::word_t got;
        errors_before = errors;
        dport_write(handler_pc, $urandom());
        pulse_irq(32'd8);
        advance_for_vector(handler_pc);
        check("uepc", uepc, prog_base + 24); // pc after the six fetches.
        advance_and_wait(v, f, got);
        check("instr_valid", v, 1'b1);
        check("handler word", got, mirror[handler_pc >> 2]);
        check("pc after handler fetch", pc, handler_pc + 4);
        finish_test("interrupt", errors_before);
    endtask

    task automatic test_contention();
        int errors_before;
        logic v;
        logic f;
        rv32im_pkg::word_t got;
        rv32im_pkg::word_t rd;
        errors_before = errors;
        dport_write(handler_pc + 4, $urandom());
        dport_write(32'h300, $urandom());
        fork
            dport_read(32'h300, rd);
            advance_and_wait(v, f, got);
        join
        check("data port read word", rd, mirror[32'h300 >> 2]);
        check("instr_valid", v, 1'b1);
        check("contended fetch word", got, mirror[(handler_pc + 4) >> 2]);
        check("pc after contended fetch", pc, handler_pc + 8);
        check("grant overlaps", grant_overlaps, 0);
        finish_test("contention", errors_before);
    endtask

    task automatic test_errors();
        int errors_before;
        logic v;
        logic f;
        logic err;
        rv32im_pkg::word_t got;
        rv32im_pkg::word_t rd;
        errors_before = errors;
        dport_access(1'b0, 32'd1024, '0, rd, err);
        check("dport_err on read at 1024", err, 1'b1);
        dport_access(1'b1, 32'd2048, $urandom(), rd, err);
        check("dport_err on write at 2048", err, 1'b1);
        dport_write(table_base + 12, bad_pc);
        pulse_irq(32'd12);
        advance_for_vector(bad_pc);
        advance_and_wait(v, f, got);
        check("fetch_fault", f, 1'b1);
        check("instr_valid on fault", v, 1'b0);
        check("pc after fault", pc, bad_pc);
        finish_test("errors", errors_before);
    endtask

    initial begin
        seed = 32'hf5122a6e;
        first_draw = $urandom(seed);
        reset = 1'b1;
        advance = 1'b0;
        irq = 1'b0;
        vtable_base = table_base;
        irq_cause = '0;
        dport_req = 1'b0;
        dport_we = 1'b0;
        dport_adr = '0;
        dport_wdat = '0;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        test_after_reset();
        test_sequential_fetch();
        test_interrupt();
        test_contention();
        test_errors();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- rv32im_pc_unit.sv
`timescale 1ns/100ps
`include "rv32im_defines.svh"

module rv32im_pc_unit (
    input  logic              clk_i,
    input  logic              reset_i,

    input  logic              data_ready_i,
    input  rv32im_pkg::word_t interrupt_pc_i,
    input  logic              interrupt_pc_write_i,
    input  logic              save_uepc_i,

    output rv32im_pkg::word_t pc_o,
    output rv32im_pkg::word_t uepc_o
);

    ////////////////////////////////////////////////////////////
    // program counter
    ////////////////////////////////////////////////////////////

    // a vector load takes precedence over the step.
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_o <= `RV32IM_RESET_PC;
        end else if (interrupt_pc_write_i) begin
            pc_o <= interrupt_pc_i;
        end else if (data_ready_i) begin
            pc_o <= pc_o + 32'd4; // next word.
        end
    end

    ////////////////////////////////////////////////////////////
    // user exception pc
    ////////////////////////////////////////////////////////////

    // captured at lookup start, before the vector overwrites pc.
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            uepc_o <= '0;
        end else if (save_uepc_i) begin
            uepc_o <= pc_o;
        end
    end

endmodule

//--- rv32im_pkg.sv
`include "rv32im_defines.svh"

package rv32im_pkg;

    // instruction or data word.
    typedef logic [`RV32IM_XLEN-1:0] word_t;

    // word address as seen on the bus.
    typedef logic [`RV32IM_WADR_W-1:0] wadr_t;

    // bus transaction state.
    // IDLE waits for a start, WAIT holds the request until the
    // slave answers, DONE is the one cycle after the answer.
    typedef enum logic [1:0] {
        IDLE = 2'b00,
        WAIT = 2'b01,
        DONE = 2'b10
    } bus_sm_e;

endpackage

//--- rv32im_prefetch.sv
`timescale 1ns/100ps
`include "rv32im_defines.svh"

module rv32im_prefetch (
    input  logic              clk_i,
    input  logic              reset_i,
    input  rv32im_pkg::word_t program_counter_i,

    input  logic              advance_i,
    output logic              data_ready_o,
    output rv32im_pkg::word_t instruction_o,
    output logic              fetch_fault_o,

    // bus master port.
    output logic              ctrl_req_o,
    input  logic              ctrl_grant_i,
    input  rv32im_pkg::word_t master_dat_i,
    input  logic              ack_i,
    input  logic              err_i,
    output rv32im_pkg::wadr_t adr_o,
    output logic              stb_o,

    // vector table lookup.
    input  logic              interrupt_trigger_i,
    input  rv32im_pkg::word_t vtable_addr_i,
    input  rv32im_pkg::word_t vtable_offset_i,
    output rv32im_pkg::word_t interrupt_pc_o,
    output logic              interrupt_pc_write_o,
    output logic              initialized_o,
    output logic              save_uepc_o
);

    rv32im_pkg::bus_sm_e vtable_sm_q;
    rv32im_pkg::bus_sm_e fetch_sm_q;
    logic                irq_pending_q;
    logic                vtable_init_q;
    logic                both_idle;
    logic                pursue_vtable;
    logic                bus_done;
    logic                vtable_complete;
    logic                fetch_complete;
    rv32im_pkg::wadr_t   vtable_adr;

    assign both_idle = (vtable_sm_q == rv32im_pkg::IDLE) &&
                       (fetch_sm_q == rv32im_pkg::IDLE);
    assign pursue_vtable = ~vtable_init_q | irq_pending_q;
    assign bus_done = ctrl_grant_i & (ack_i | err_i); // answer meant for us.
    assign vtable_complete = (vtable_sm_q == rv32im_pkg::WAIT) & bus_done;
    assign fetch_complete = (fetch_sm_q == rv32im_pkg::WAIT) & bus_done;

    // base and offset both taken as word addresses.
    assign vtable_adr = vtable_addr_i[`RV32IM_XLEN-1:2] + vtable_offset_i[`RV32IM_XLEN-1:2];

    // trigger wins so an irq landing on a completing lookup is kept.
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            irq_pending_q <= 1'b0;
        end else if (interrupt_trigger_i) begin
            irq_pending_q <= 1'b1;
        end else if (vtable_complete) begin
            irq_pending_q <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // state machines
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            vtable_sm_q          <= rv32im_pkg::IDLE;
            fetch_sm_q           <= rv32im_pkg::IDLE;
            vtable_init_q        <= 1'b0;
            ctrl_req_o           <= 1'b0;
            stb_o                <= 1'b0;
            data_ready_o         <= 1'b0;
            fetch_fault_o        <= 1'b0;
            interrupt_pc_write_o <= 1'b0;
            save_uepc_o          <= 1'b0;
            initialized_o        <= 1'b0;
        end else begin
            data_ready_o         <= 1'b0; // pulses.
            fetch_fault_o        <= 1'b0;
            interrupt_pc_write_o <= 1'b0;
            save_uepc_o          <= 1'b0;

            case (vtable_sm_q)
                rv32im_pkg::IDLE: begin
                    if (advance_i && both_idle && pursue_vtable) begin
                        ctrl_req_o  <= 1'b1;
                        stb_o       <= 1'b1;
                        save_uepc_o <= 1'b1;
                        vtable_sm_q <= rv32im_pkg::WAIT;
                    end
                end
                rv32im_pkg::WAIT: begin
                    if (bus_done) begin
                        ctrl_req_o           <= 1'b0;
                        stb_o                <= 1'b0;
                        interrupt_pc_write_o <= ack_i; // an err leaves the pc alone.
                        vtable_init_q        <= 1'b1;
                        vtable_sm_q          <= rv32im_pkg::DONE;
                    end
                end
                default: vtable_sm_q <= rv32im_pkg::IDLE;
            endcase

            case (fetch_sm_q)
                rv32im_pkg::IDLE: begin
                    if (advance_i && both_idle && !pursue_vtable) begin
                        ctrl_req_o    <= 1'b1;
                        stb_o         <= 1'b1;
                        initialized_o <= 1'b1;
                        fetch_sm_q    <= rv32im_pkg::WAIT;
                    end
                end
                rv32im_pkg::WAIT: begin
                    if (bus_done) begin
                        ctrl_req_o    <= 1'b0;
                        stb_o         <= 1'b0;
                        data_ready_o  <= ack_i;
                        fetch_fault_o <= err_i & ~ack_i;
                        fetch_sm_q    <= rv32im_pkg::DONE;
                    end
                end
                default: fetch_sm_q <= rv32im_pkg::IDLE;
            endcase
        end
    end

    // address and returned words.
    always_ff @(posedge clk_i) begin
        if (advance_i && both_idle) begin
            adr_o <= pursue_vtable ? vtable_adr : program_counter_i[`RV32IM_XLEN-1:2];
        end
        if (fetch_complete) begin
            instruction_o <= master_dat_i;
        end
        if (vtable_complete) begin
            interrupt_pc_o <= master_dat_i;
        end
    end

    adr_stable_in_request: assert property (@(posedge clk_i) disable iff (reset_i)
        ctrl_req_o |=> $stable(adr_o));

    ready_single_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
        data_ready_o |=> !data_ready_o);

endmodule

//--- rv32im_wb_memory.sv
`timescale 1ns/100ps
`include "rv32im_defines.svh"

module rv32im_wb_memory (
    input  logic              clk_i,
    input  logic              reset_i,

    input  logic              cyc_i,
    input  logic              stb_i,
    input  logic              we_i,
    input  rv32im_pkg::wadr_t adr_i,
    input  rv32im_pkg::word_t dat_i,

    output rv32im_pkg::word_t dat_o,
    output logic              ack_o,
    output logic              err_o
);

    localparam int unsigned mem_aw = $clog2(`RV32IM_MEM_WORDS);

    rv32im_pkg::word_t mem_q [`RV32IM_MEM_WORDS];
    logic              served_q; // answered, waiting for stb to drop.
    logic              access;
    logic              in_range;
    logic [mem_aw-1:0] idx;

    assign access   = cyc_i & stb_i & ~served_q;
    assign in_range = (adr_i < rv32im_pkg::wadr_t'(`RV32IM_MEM_WORDS));
    assign idx      = adr_i[mem_aw-1:0];

    ////////////////////////////////////////////////////////////
    // response
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ack_o    <= 1'b0;
            err_o    <= 1'b0;
            served_q <= 1'b0;
        end else begin
            ack_o <= access & in_range;
            err_o <= access & ~in_range; // out of range.
            if (access) begin
                served_q <= 1'b1;
            end else if (!(cyc_i && stb_i)) begin
                served_q <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (access && in_range) begin
            if (we_i) begin
                mem_q[idx] <= dat_i;
            end else begin
                dat_o <= mem_q[idx];
            end
        end
    end

endmodule
